// File: logic/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath and address width
`define EX_DATA_W 32

// register file index width
`define EX_REG_ADDR_W 5

// byte distance to the next sequential instruction
`define EX_PC_STEP 4

// link instructions write pc plus this value
// (skips the delay slot)
`define EX_LINK_OFFSET 8

`endif

// File: logic/ex_isa_pkg.sv
`default_nettype none

package ex_isa_pkg;

    // alu operations, ADD at zero so a cleared register decodes as ADD
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } alu_op_e;

    // first alu operand source
    typedef enum logic [1:0] {
        SRC1_RS = 2'd0,
        SRC1_PC = 2'd1,
        SRC1_SA = 2'd2
    } src1_sel_e;

    // second alu operand source
    typedef enum logic [1:0] {
        SRC2_RT       = 2'd0,
        SRC2_IMM_SEXT = 2'd1,
        SRC2_LINK     = 2'd2,
        SRC2_IMM_ZEXT = 2'd3
    } src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE   = 4'd0,
        BR_BEQ    = 4'd1,
        BR_BNE    = 4'd2,
        BR_BGEZ   = 4'd3,
        BR_BGTZ   = 4'd4,
        BR_BLEZ   = 4'd5,
        BR_BLTZ   = 4'd6,
        BR_BGEZAL = 4'd7,
        BR_BLTZAL = 4'd8,
        BR_J      = 4'd9,
        BR_JAL    = 4'd10,
        BR_JR     = 4'd11,
        BR_JALR   = 4'd12
    } branch_op_e;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

endpackage

`default_nettype wire

// File: logic/ex_pipe_pkg.sv
`include "ex_cfg.svh"
`default_nettype none

package ex_pipe_pkg;

    import ex_isa_pkg::*;

    // instruction as delivered by decode
    typedef struct packed {
        logic [`EX_DATA_W-1:0]     pc;
        logic [`EX_DATA_W-1:0]     inst;
        alu_op_e                   alu_op;
        src1_sel_e                 src1_sel;
        src2_sel_e                 src2_sel;
        branch_op_e                branch_op;
        mem_op_e                   mem_op;
        logic                      rf_we;
        logic [`EX_REG_ADDR_W-1:0] rf_waddr;
        logic [`EX_DATA_W-1:0]     rs_data;
        logic [`EX_DATA_W-1:0]     rt_data;
    } id_to_ex_t;

    // registered instruction after forwarding and operand muxing
    typedef struct packed {
        logic [`EX_DATA_W-1:0]     pc;
        logic [`EX_DATA_W-1:0]     inst;
        alu_op_e                   alu_op;
        branch_op_e                branch_op;
        mem_op_e                   mem_op;
        logic                      rf_we;
        logic [`EX_REG_ADDR_W-1:0] rf_waddr;
        logic [`EX_DATA_W-1:0]     src1;
        logic [`EX_DATA_W-1:0]     src2;
        logic [`EX_DATA_W-1:0]     rs_val;
        logic [`EX_DATA_W-1:0]     rt_val;
        logic                      in_delay_slot;
    } operands_t;

    // bypass from a later stage for one source register
    typedef struct packed {
        logic                  sel;
        logic [`EX_DATA_W-1:0] data;
    } forward_t;

    typedef struct packed {
        logic                  taken;
        logic [`EX_DATA_W-1:0] target;
    } branch_t;

    // data memory request, one write enable per byte lane
    typedef struct packed {
        logic                      en;
        logic [`EX_DATA_W/8-1:0]   wen;
        logic [`EX_DATA_W-1:0]     addr;
        logic [`EX_DATA_W-1:0]     wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [`EX_DATA_W-1:0]     pc;
        logic [`EX_DATA_W-1:0]     result;
        logic                      rf_we;
        logic [`EX_REG_ADDR_W-1:0] rf_waddr;
        mem_op_e                   mem_op;
        logic                      in_delay_slot;
        logic                      ovf;
        logic                      adel;
        logic                      ades;
        logic [`EX_DATA_W-1:0]     bad_vaddr;
    } ex_to_mem_t;

endpackage

`default_nettype wire

// File: logic/ex_decode.sv
`include "ex_cfg.svh"
`default_nettype none

module ex_decode (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush_i,
    input  wire logic                   stall_i,
    input  wire logic                   next_stall_i,
    input  wire ex_pipe_pkg::id_to_ex_t id_to_ex_i,
    input  wire ex_pipe_pkg::forward_t  rs_fwd_i,
    input  wire ex_pipe_pkg::forward_t  rt_fwd_i,
    output ex_pipe_pkg::operands_t      ops_o
);

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam logic [`EX_DATA_W-1:0] LINK_OFFSET = `EX_LINK_OFFSET;

    id_to_ex_t             id_q;
    logic                  in_slot_q;
    logic                  bubble;
    logic [`EX_DATA_W-1:0] rs_val;
    logic [`EX_DATA_W-1:0] rt_val;
    logic [`EX_DATA_W-1:0] imm_sext;
    logic [`EX_DATA_W-1:0] imm_zext;
    logic [`EX_DATA_W-1:0] sa_zext;

    // this stage stalls while the next one moves on
    assign bubble = stall_i && !next_stall_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i || bubble) begin
            id_q      <= '0;
            in_slot_q <= 1'b0;
        end else if (!stall_i) begin
            id_q      <= id_to_ex_i;
            // the previous occupant was a branch or jump
            in_slot_q <= (id_q.branch_op != BR_NONE);
        end
    end

    // late bypass overrides the value read in decode
    assign rs_val = rs_fwd_i.sel ? rs_fwd_i.data : id_q.rs_data;
    assign rt_val = rt_fwd_i.sel ? rt_fwd_i.data : id_q.rt_data;

    assign imm_sext = {{(`EX_DATA_W-16){id_q.inst[15]}}, id_q.inst[15:0]};
    assign imm_zext = {{(`EX_DATA_W-16){1'b0}}, id_q.inst[15:0]};
    assign sa_zext  = {{(`EX_DATA_W-5){1'b0}}, id_q.inst[10:6]};

    always_comb begin
        ops_o.pc            = id_q.pc;
        ops_o.inst          = id_q.inst;
        ops_o.alu_op        = id_q.alu_op;
        ops_o.branch_op     = id_q.branch_op;
        ops_o.mem_op        = id_q.mem_op;
        ops_o.rf_we         = id_q.rf_we;
        ops_o.rf_waddr      = id_q.rf_waddr;
        ops_o.rs_val        = rs_val;
        ops_o.rt_val        = rt_val;
        ops_o.in_delay_slot = in_slot_q;

        case (id_q.src1_sel)
            SRC1_PC: ops_o.src1 = id_q.pc;
            SRC1_SA: ops_o.src1 = sa_zext;
            default: ops_o.src1 = rs_val;
        endcase

        case (id_q.src2_sel)
            SRC2_IMM_SEXT: ops_o.src2 = imm_sext;
            SRC2_LINK:     ops_o.src2 = LINK_OFFSET;
            SRC2_IMM_ZEXT: ops_o.src2 = imm_zext;
            default:       ops_o.src2 = rt_val;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/ex_alu.sv
`include "ex_cfg.svh"
`default_nettype none

module ex_alu (
    input  wire ex_pipe_pkg::operands_t ops_i,
    output logic [`EX_DATA_W-1:0]       result_o,
    output logic                        ovf_o
);

    import ex_isa_pkg::*;

    localparam int SHAMT_W = $clog2(`EX_DATA_W);
    localparam int HALF_W  = `EX_DATA_W / 2;

    logic [`EX_DATA_W-1:0] a;
    logic [`EX_DATA_W-1:0] b;
    logic [`EX_DATA_W-1:0] sum;
    logic [`EX_DATA_W-1:0] diff;
    logic [SHAMT_W-1:0]    shamt;
    logic                  add_ovf;
    logic                  sub_ovf;

    assign a     = ops_i.src1;
    assign b     = ops_i.src2;
    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[SHAMT_W-1:0];

    // same signs in, other sign out
    assign add_ovf = (a[`EX_DATA_W-1] == b[`EX_DATA_W-1]) &&
                     (sum[`EX_DATA_W-1] != a[`EX_DATA_W-1]);
    // subtrahend of the other sign flips the result
    assign sub_ovf = (a[`EX_DATA_W-1] != b[`EX_DATA_W-1]) &&
                     (diff[`EX_DATA_W-1] != a[`EX_DATA_W-1]);

    always_comb begin
        case (ops_i.alu_op)
            ALU_ADD, ALU_ADDU: result_o = sum;
            ALU_SUB, ALU_SUBU: result_o = diff;
            ALU_AND:  result_o = a & b;
            ALU_OR:   result_o = a | b;
            ALU_XOR:  result_o = a ^ b;
            ALU_NOR:  result_o = ~(a | b);
            ALU_SLT:  result_o = {{(`EX_DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result_o = {{(`EX_DATA_W-1){1'b0}}, a < b};
            ALU_SLL:  result_o = b << shamt;
            ALU_SRL:  result_o = b >> shamt;
            ALU_SRA:  result_o = $signed(b) >>> shamt;
            ALU_LUI:  result_o = {b[HALF_W-1:0], {HALF_W{1'b0}}};
            default:  result_o = '0;
        endcase
    end

    // only the trapping forms report overflow
    assign ovf_o = ((ops_i.alu_op == ALU_ADD) && add_ovf) ||
                   ((ops_i.alu_op == ALU_SUB) && sub_ovf);

endmodule

`default_nettype wire

// File: logic/ex_branch.sv
`include "ex_cfg.svh"
`default_nettype none

module ex_branch (
    input  wire ex_pipe_pkg::operands_t ops_i,
    output ex_pipe_pkg::branch_t        branch_o
);

    import ex_isa_pkg::*;

    localparam logic [`EX_DATA_W-1:0] PC_STEP = `EX_PC_STEP;

    logic [`EX_DATA_W-1:0] pc_next;
    logic [`EX_DATA_W-1:0] br_offset;
    logic [`EX_DATA_W-1:0] cond_target;
    logic [`EX_DATA_W-1:0] jump_target;
    logic                  rs_eq_rt;
    logic                  rs_neg;
    logic                  rs_zero;

    assign pc_next     = ops_i.pc + PC_STEP;
    // word offset, sign extended
    assign br_offset   = {{(`EX_DATA_W-18){ops_i.inst[15]}}, ops_i.inst[15:0], 2'b00};
    assign cond_target = pc_next + br_offset;
    // region bits come from the delay slot address
    assign jump_target = {pc_next[`EX_DATA_W-1:`EX_DATA_W-4], ops_i.inst[25:0], 2'b00};

    assign rs_eq_rt = (ops_i.rs_val == ops_i.rt_val);
    assign rs_neg   = ops_i.rs_val[`EX_DATA_W-1];
    assign rs_zero  = (ops_i.rs_val == '0);

    always_comb begin
        case (ops_i.branch_op)
            BR_BEQ:               branch_o.taken = rs_eq_rt;
            BR_BNE:               branch_o.taken = !rs_eq_rt;
            BR_BGEZ, BR_BGEZAL:   branch_o.taken = !rs_neg;
            BR_BGTZ:              branch_o.taken = !rs_neg && !rs_zero;
            BR_BLEZ:              branch_o.taken = rs_neg || rs_zero;
            BR_BLTZ, BR_BLTZAL:   branch_o.taken = rs_neg;
            BR_J, BR_JAL,
            BR_JR, BR_JALR:       branch_o.taken = 1'b1;
            default:              branch_o.taken = 1'b0;
        endcase

        case (ops_i.branch_op)
            BR_NONE:         branch_o.target = '0;
            BR_J, BR_JAL:    branch_o.target = jump_target;
            BR_JR, BR_JALR:  branch_o.target = ops_i.rs_val;
            default:         branch_o.target = cond_target;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/ex_result.sv
`include "ex_cfg.svh"
`default_nettype none

module ex_result (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush_i,
    input  wire ex_pipe_pkg::operands_t ops_i,
    input  wire logic [`EX_DATA_W-1:0]  alu_result_i,
    input  wire logic                   alu_ovf_i,
    output ex_pipe_pkg::dmem_req_t      dmem_o,
    output ex_pipe_pkg::ex_to_mem_t     ex_to_mem_o
);

    import ex_isa_pkg::*;

    localparam int LANES = `EX_DATA_W / 8;
    localparam int HALF  = LANES / 2;

    logic [`EX_DATA_W-1:0] addr;
    logic [`EX_DATA_W-1:0] wdata;
    logic [LANES-1:0]      wen;
    logic                  is_load;
    logic                  is_store;
    logic                  ovf;
    logic                  adel;
    logic                  ades;
    logic                  exc;
    logic                  store_block_q;

    // effective address comes out of the alu
    assign addr = alu_result_i;

    assign is_load  = (ops_i.mem_op == MEM_LB) || (ops_i.mem_op == MEM_LBU) ||
                      (ops_i.mem_op == MEM_LH) || (ops_i.mem_op == MEM_LHU) ||
                      (ops_i.mem_op == MEM_LW);
    assign is_store = (ops_i.mem_op == MEM_SB) || (ops_i.mem_op == MEM_SH) ||
                      (ops_i.mem_op == MEM_SW);

    // store data is replicated, the lane enables pick the bytes
    always_comb begin
        case (ops_i.mem_op)
            MEM_SB: begin
                wdata = {LANES{ops_i.rt_val[7:0]}};
                wen   = {{(LANES-1){1'b0}}, 1'b1} << addr[1:0];
            end
            MEM_SH: begin
                wdata = {2{ops_i.rt_val[`EX_DATA_W/2-1:0]}};
                wen   = addr[1] ? {{HALF{1'b1}}, {HALF{1'b0}}} :
                                  {{HALF{1'b0}}, {HALF{1'b1}}};
            end
            MEM_SW: begin
                wdata = ops_i.rt_val;
                wen   = {LANES{1'b1}};
            end
            default: begin
                wdata = '0;
                wen   = '0;
            end
        endcase
    end

    // halfword needs even, word needs four byte alignment
    assign adel = (((ops_i.mem_op == MEM_LH) || (ops_i.mem_op == MEM_LHU)) && addr[0]) ||
                  ((ops_i.mem_op == MEM_LW) && (addr[1:0] != 2'b00));
    assign ades = ((ops_i.mem_op == MEM_SH) && addr[0]) ||
                  ((ops_i.mem_op == MEM_SW) && (addr[1:0] != 2'b00));

    // overflow counts only for an instruction that writes back
    // (a bubble still decodes as ADD on forwarded data)
    assign ovf = alu_ovf_i && ops_i.rf_we;
    assign exc = ovf || adel || ades;

    // once an exception is seen nothing reaches memory until the flush
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            store_block_q <= 1'b0;
        end else if (exc) begin
            store_block_q <= 1'b1;
        end
    end

    always_comb begin
        dmem_o.en    = (is_load || is_store) && !exc && !store_block_q;
        dmem_o.wen   = wen;
        dmem_o.addr  = addr;
        dmem_o.wdata = wdata;

        ex_to_mem_o.pc            = ops_i.pc;
        ex_to_mem_o.result        = alu_result_i;
        ex_to_mem_o.rf_we         = ops_i.rf_we;
        ex_to_mem_o.rf_waddr      = ops_i.rf_waddr;
        ex_to_mem_o.mem_op        = ops_i.mem_op;
        ex_to_mem_o.in_delay_slot = ops_i.in_delay_slot;
        ex_to_mem_o.ovf           = ovf;
        ex_to_mem_o.adel          = adel;
        ex_to_mem_o.ades          = ades;
        ex_to_mem_o.bad_vaddr     = alu_result_i;
    end

endmodule

`default_nettype wire

// File: logic/ex_stage.sv
`include "ex_cfg.svh"
`default_nettype none

module ex_stage (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush_i,
    input  wire logic                   stall_i,
    input  wire logic                   next_stall_i,
    input  wire ex_pipe_pkg::id_to_ex_t id_to_ex_i,
    input  wire ex_pipe_pkg::forward_t  rs_fwd_i,
    input  wire ex_pipe_pkg::forward_t  rt_fwd_i,
    output ex_pipe_pkg::branch_t        branch_o,
    output ex_pipe_pkg::dmem_req_t      dmem_o,
    output ex_pipe_pkg::ex_to_mem_t     ex_to_mem_o
);

    import ex_pipe_pkg::*;

    operands_t             ops;
    logic [`EX_DATA_W-1:0] alu_result;
    logic                  alu_ovf;

    // pipeline register and operand muxing
    ex_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .next_stall_i (next_stall_i),
        .id_to_ex_i   (id_to_ex_i),
        .rs_fwd_i     (rs_fwd_i),
        .rt_fwd_i     (rt_fwd_i),
        .ops_o        (ops)
    );

    ex_alu u_alu (
        .ops_i    (ops),
        .result_o (alu_result),
        .ovf_o    (alu_ovf)
    );

    // resolved in this stage, fetch redirects on taken
    ex_branch u_branch (
        .ops_i    (ops),
        .branch_o (branch_o)
    );

    ex_result u_result (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .ops_i        (ops),
        .alu_result_i (alu_result),
        .alu_ovf_i    (alu_ovf),
        .dmem_o       (dmem_o),
        .ex_to_mem_o  (ex_to_mem_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_ex_stage.sv
`include "ex_cfg.svh"
`default_nettype none

module tb_ex_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int STIM_CYCLES    = 14 * 3 * 4 + 12 * 3 * 2 + 80;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;

    logic       clk;
    logic       rst;
    logic       flush;
    logic       stall;
    logic       next_stall;
    id_to_ex_t  id_in;
    forward_t   rs_fwd;
    forward_t   rt_fwd;
    branch_t    branch;
    dmem_req_t  dmem;
    ex_to_mem_t ex_out;

    integer     seed = 39058;
    logic       started = 1'b0;
    string      test_name = "reset";

    // reference copy of the stage register
    id_to_ex_t  m_id;
    logic       m_slot;
    logic       m_block;

    logic [31:0] e_rs;
    logic [31:0] e_rt;
    logic [31:0] e_src1;
    logic [31:0] e_src2;
    logic [31:0] e_res;
    logic [31:0] e_wdata;
    logic [31:0] e_target;
    logic [32:0] e_wide;
    logic [31:0] e_pc4;
    logic [3:0]  e_wen;
    logic [1:0]  e_off;
    logic        e_ovf;
    logic        e_adel;
    logic        e_ades;
    logic        e_en;
    logic        e_taken;

    ex_stage dut (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush),
        .stall_i      (stall),
        .next_stall_i (next_stall),
        .id_to_ex_i   (id_in),
        .rs_fwd_i     (rs_fwd),
        .rt_fwd_i     (rt_fwd),
        .branch_o     (branch),
        .dmem_o       (dmem),
        .ex_to_mem_o  (ex_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the stimulus did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // expected outputs from the instruction rules
    always_comb begin
        e_rs = rs_fwd.sel ? rs_fwd.data : m_id.rs_data;
        e_rt = rt_fwd.sel ? rt_fwd.data : m_id.rt_data;
        case (m_id.src1_sel)
            SRC1_PC: e_src1 = m_id.pc;
            SRC1_SA: e_src1 = 32'(m_id.inst[10:6]);
            default: e_src1 = e_rs;
        endcase
        case (m_id.src2_sel)
            SRC2_IMM_SEXT: e_src2 = {{16{m_id.inst[15]}}, m_id.inst[15:0]};
            SRC2_LINK:     e_src2 = 32'd8;
            SRC2_IMM_ZEXT: e_src2 = {16'h0000, m_id.inst[15:0]};
            default:       e_src2 = e_rt;
        endcase
        e_wide = 33'd0;
        case (m_id.alu_op)
            ALU_ADD, ALU_ADDU: e_res = e_src1 + e_src2;
            ALU_SUB, ALU_SUBU: e_res = e_src1 - e_src2;
            ALU_AND:  e_res = e_src1 & e_src2;
            ALU_OR:   e_res = e_src1 | e_src2;
            ALU_XOR:  e_res = e_src1 ^ e_src2;
            ALU_NOR:  e_res = ~(e_src1 | e_src2);
            ALU_SLT:  e_res = ($signed(e_src1) < $signed(e_src2)) ? 32'd1 : 32'd0;
            ALU_SLTU: e_res = (e_src1 < e_src2) ? 32'd1 : 32'd0;
            ALU_SLL:  e_res = e_src2 << e_src1[4:0];
            ALU_SRL:  e_res = e_src2 >> e_src1[4:0];
            ALU_SRA:  e_res = $signed(e_src2) >>> e_src1[4:0];
            ALU_LUI:  e_res = {e_src2[15:0], 16'h0000};
            default:  e_res = 32'd0;
        endcase
        // 33-bit signed sum, overflow when the top two bits differ
        if (m_id.alu_op == ALU_ADD) begin
            e_wide = {e_src1[31], e_src1} + {e_src2[31], e_src2};
        end else if (m_id.alu_op == ALU_SUB) begin
            e_wide = {e_src1[31], e_src1} - {e_src2[31], e_src2};
        end
        e_ovf = (e_wide[32] != e_wide[31]) && m_id.rf_we;
        e_off = e_res[1:0];
        e_adel = ((m_id.mem_op == MEM_LH || m_id.mem_op == MEM_LHU) && e_off[0]) ||
                 (m_id.mem_op == MEM_LW && e_off != 2'b00);
        e_ades = (m_id.mem_op == MEM_SH && e_off[0]) ||
                 (m_id.mem_op == MEM_SW && e_off != 2'b00);
        case (m_id.mem_op)
            MEM_SB: begin
                e_wen   = 4'b0001 << e_off;
                e_wdata = {4{e_rt[7:0]}};
            end
            MEM_SH: begin
                e_wen   = e_off[1] ? 4'b1100 : 4'b0011;
                e_wdata = {2{e_rt[15:0]}};
            end
            MEM_SW: begin
                e_wen   = 4'b1111;
                e_wdata = e_rt;
            end
            default: begin
                e_wen   = 4'b0000;
                e_wdata = 32'd0;
            end
        endcase
        e_en = (m_id.mem_op != MEM_NONE) && !(e_ovf || e_adel || e_ades) && !m_block;
        e_pc4 = m_id.pc + 32'd4;
        case (m_id.branch_op)
            BR_BEQ:             e_taken = (e_rs == e_rt);
            BR_BNE:             e_taken = (e_rs != e_rt);
            BR_BGEZ, BR_BGEZAL: e_taken = ($signed(e_rs) >= 0);
            BR_BGTZ:            e_taken = ($signed(e_rs) > 0);
            BR_BLEZ:            e_taken = ($signed(e_rs) <= 0);
            BR_BLTZ, BR_BLTZAL: e_taken = ($signed(e_rs) < 0);
            BR_J, BR_JAL, BR_JR, BR_JALR: e_taken = 1'b1;
            default:            e_taken = 1'b0;
        endcase
        case (m_id.branch_op)
            BR_J, BR_JAL:   e_target = {e_pc4[31:28], m_id.inst[25:0], 2'b00};
            BR_JR, BR_JALR: e_target = e_rs;
            default: e_target = e_pc4 + {{14{m_id.inst[15]}}, m_id.inst[15:0], 2'b00};
        endcase
    end

    always @(posedge clk) begin
        started <= 1'b1;
        if (rst || flush || (stall && !next_stall)) begin
            m_id   <= '0;
            m_slot <= 1'b0;
        end else if (!stall) begin
            m_id   <= id_in;
            m_slot <= (m_id.branch_op != BR_NONE);
        end
        if (rst || flush) begin
            m_block <= 1'b0;
        end else if (e_ovf || e_adel || e_ades) begin
            m_block <= 1'b1;
        end
    end

    task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s: %s expected %h actual %h", test_name, field, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (started) begin
            check("branch taken", 32'(e_taken), 32'(branch.taken));
            // every branch or jump carries its target, taken or not
            if (m_id.branch_op != BR_NONE) begin
                check("branch target", e_target, branch.target);
            end
            check("dmem en", 32'(e_en), 32'(dmem.en));
            check("dmem wen", 32'(e_wen), 32'(dmem.wen));
            check("dmem addr", e_res, dmem.addr);
            check("dmem wdata", e_wdata, dmem.wdata);
            check("pc", m_id.pc, ex_out.pc);
            check("result", e_res, ex_out.result);
            check("rf_we", 32'(m_id.rf_we), 32'(ex_out.rf_we));
            check("rf_waddr", 32'(m_id.rf_waddr), 32'(ex_out.rf_waddr));
            check("mem_op", 32'(m_id.mem_op), 32'(ex_out.mem_op));
            check("in_delay_slot", 32'(m_slot), 32'(ex_out.in_delay_slot));
            check("ovf", 32'(e_ovf), 32'(ex_out.ovf));
            check("adel", 32'(e_adel), 32'(ex_out.adel));
            check("ades", 32'(e_ades), 32'(ex_out.ades));
            check("bad_vaddr", e_res, ex_out.bad_vaddr);
        end
    end

    function automatic id_to_ex_t make_op(input alu_op_e alu, input src1_sel_e s1,
                                          input src2_sel_e s2, input branch_op_e br,
                                          input mem_op_e mem, input logic we,
                                          input logic [31:0] rs, input logic [31:0] rt,
                                          input logic [31:0] inst);
        id_to_ex_t   t;
        logic [31:0] w;
        w = $random(seed);
        t.pc        = {w[31:2], 2'b00};
        t.inst      = inst;
        t.alu_op    = alu;
        t.src1_sel  = s1;
        t.src2_sel  = s2;
        t.branch_op = br;
        t.mem_op    = mem;
        t.rf_we     = we;
        w = $random(seed);
        t.rf_waddr  = w[4:0];
        t.rs_data   = rs;
        t.rt_data   = rt;
        return t;
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic send_fwd(input id_to_ex_t item, input logic rs_sel, input logic rt_sel);
        @(posedge clk);
        id_in  <= item;
        rs_fwd <= '{sel: rs_sel, data: rand_word()};
        rt_fwd <= '{sel: rt_sel, data: rand_word()};
    endtask

    task automatic send(input id_to_ex_t item);
        send_fwd(item, 1'b0, 1'b0);
    endtask

    task automatic flush_pulse();
        @(posedge clk);
        flush <= 1'b1;
        id_in <= '0;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // store or load with the base aligned and the offset in the immediate
    task automatic mem_at(input mem_op_e m, input int off);
        logic [31:0] inst;
        inst = rand_word();
        inst[15:0] = 16'(off);
        send(make_op(ALU_ADDU, SRC1_RS, SRC2_IMM_SEXT, BR_NONE, m, m <= MEM_LW,
                     rand_word() & 32'hffff_fff0, rand_word(), inst));
    endtask

    initial begin
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] w;
        rst        <= 1'b1;
        flush      <= 1'b0;
        stall      <= 1'b0;
        next_stall <= 1'b0;
        id_in      <= '0;
        rs_fwd     <= '0;
        rt_fwd     <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        test_name = "alu operations";
        for (int op = 0; op < 14; op++) begin
            for (int s1 = 0; s1 < 3; s1++) begin
                for (int s2 = 0; s2 < 4; s2++) begin
                    w = rand_word();
                    send_fwd(make_op(alu_op_e'(op[3:0]), src1_sel_e'(s1[1:0]),
                                     src2_sel_e'(s2[1:0]), BR_NONE, MEM_NONE, 1'b1,
                                     rand_word(), rand_word(), rand_word()), w[0], w[1]);
                end
            end
        end
        flush_pulse();

        test_name = "overflow";
        send(make_op(ALU_ADD, SRC1_RS, SRC2_RT, BR_NONE, MEM_SW, 1'b1,
                     32'h7fff_ffff, 32'h1, rand_word()));
        flush_pulse();
        send(make_op(ALU_SUB, SRC1_RS, SRC2_RT, BR_NONE, MEM_SW, 1'b1,
                     32'h8000_0000, 32'h4, rand_word()));
        flush_pulse();
        send(make_op(ALU_ADDU, SRC1_RS, SRC2_RT, BR_NONE, MEM_SW, 1'b1,
                     32'h7fff_ffff, 32'h1, rand_word()));
        send(make_op(ALU_SUBU, SRC1_RS, SRC2_RT, BR_NONE, MEM_SW, 1'b1,
                     32'h8000_0000, 32'h4, rand_word()));

        test_name = "branches";
        for (int br = 1; br < 13; br++) begin
            for (int v = 0; v < 3; v++) begin
                rs = rand_word();
                rt = (v == 1) ? rs : rand_word();
                if (v == 2) begin
                    rs = 32'd0;
                end
                send(make_op(ALU_ADDU, SRC1_PC, SRC2_LINK, branch_op_e'(br[3:0]), MEM_NONE,
                             1'b1, rs, rt, rand_word()));
                // delay slot instruction
                send(make_op(ALU_OR, SRC1_RS, SRC2_RT, BR_NONE, MEM_NONE, 1'b1,
                             rand_word(), rand_word(), rand_word()));
            end
        end

        test_name = "store lanes";
        flush_pulse();
        for (int off = 0; off < 4; off++) begin
            mem_at(MEM_SB, off);
        end
        mem_at(MEM_SH, 0);
        mem_at(MEM_SH, 2);
        mem_at(MEM_SW, 0);

        test_name = "address errors";
        mem_at(MEM_LH, 1);
        mem_at(MEM_SW, 0);
        flush_pulse();
        mem_at(MEM_LW, 2);
        mem_at(MEM_SW, 4);
        flush_pulse();
        mem_at(MEM_SH, 3);
        mem_at(MEM_SW, 8);
        flush_pulse();
        mem_at(MEM_SW, 1);
        mem_at(MEM_SB, 2);
        mem_at(MEM_SW, 0);
        flush_pulse();
        mem_at(MEM_SW, 0);

        test_name = "stall and flush";
        @(posedge clk);
        stall      <= 1'b1;
        next_stall <= 1'b1;
        repeat (3) begin
            mem_at(MEM_SB, 1);
        end
        @(posedge clk);
        next_stall <= 1'b0;
        @(posedge clk);
        stall <= 1'b0;
        mem_at(MEM_SW, 4);
        flush_pulse();
        repeat (3) @(posedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/ex_isa_pkg.sv
logic/ex_pipe_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_result.sv
logic/ex_stage.sv
tb/tb_ex_stage.sv

// File: Makefile
TB_TOP = tb_ex_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module ex_stage

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
